/* src.f */
+incdir+hdl
hdl/tlp_pkg.sv
hdl/tlp_stream_if.sv
hdl/tlp_skid_buffer.sv
hdl/afu_csr.sv
hdl/mmio_responder.sv
hdl/mmio_endpoint_top.sv
sim/tb_clock_gen.sv
sim/mmio_endpoint_asserts.sv
sim/tb_mmio_endpoint.sv

/* Bender.yml */
package:
  name: mmio_endpoint

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/tlp_pkg.sv
      - hdl/tlp_stream_if.sv
      - hdl/tlp_skid_buffer.sv
      - hdl/afu_csr.sv
      - hdl/mmio_responder.sv
      - hdl/mmio_endpoint_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/mmio_endpoint_asserts.sv
      - sim/tb_mmio_endpoint.sv

/* sim/tb_mmio_endpoint.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMIO endpoint testbench
// Directed and random requests, reference model,
// completion checks and the watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "mmio_defines.svh"

module tb_mmio_endpoint;

    localparam logic [31:0] SEED = 32'h386ebe8d;
    localparam int N_DIRECTED = 16;
    localparam int N_RANDOM = 64;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 40 + 200;

    // PCIe fmt/type codes and two more types that the endpoint must drop
    localparam logic [7:0] MRD32 = 8'h00;
    localparam logic [7:0] MRD64 = 8'h20;
    localparam logic [7:0] MWR32 = 8'h40;
    localparam logic [7:0] MWR64 = 8'h60;
    localparam logic [7:0] CPLD = 8'h4a;
    localparam logic [7:0] CFGRD0 = 8'h04;
    localparam logic [7:0] CPL = 8'h0a;

    // AFU feature header with type 1 in the top nibble and end of list in bit 40
    localparam logic [63:0] DFH_VALUE = (64'h1 << 60) | (64'h1 << 40);

    logic                   clk;
    logic                   reset_n;
    logic                   rx_valid;
    logic                   rx_ready;
    logic [`TLP_HDR_W-1:0]  rx_hdr;
    logic [`TLP_DATA_W-1:0] rx_data;
    logic                   tx_valid;
    logic                   tx_ready;
    logic [`TLP_HDR_W-1:0]  tx_hdr;
    logic [`TLP_DATA_W-1:0] tx_data;

    // Separate generator states keep stimulus and back-pressure independent
    logic [31:0]            stim_state;
    logic [31:0]            bp_state;
    logic [63:0]            model_scratch;
    logic [127:0]           exp_hdr_q[$];
    logic [63:0]            exp_data_q[$];

    tb_clock_gen u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    mmio_endpoint_top u_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_hdr   (rx_hdr),
        .rx_data  (rx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_hdr   (tx_hdr),
        .tx_data  (tx_data)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Register contents as the host should see them at this point of the run
    function automatic logic [63:0] expected_csr(input logic [1:0] idx);
        case (idx)
            `CSR_IDX_DFH:  return DFH_VALUE;
            `CSR_IDX_ID_L: return `AFU_ID_L;
            `CSR_IDX_ID_H: return `AFU_ID_H;
            default:       return model_scratch;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        assert (actual === expected)
        else
        begin
            $display("FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic idle_cycles(input int n);
        rx_valid = 1'b0;
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // Builds one request beat, updates the model, then holds it until accepted
    task automatic issue_request(input logic [7:0] fmttype, input logic [6:0] low_addr,
                                 input logic [9:0] length, input logic [63:0] payload);
        logic        four_dw;
        logic        accepted;
        logic [15:0] req_id;
        logic [7:0]  tag;
        logic [31:0] word_a;
        logic [31:0] word_b;
        logic [31:0] addr_word;
        logic [31:0] lsb_word;
        stim_state = lcg_step(stim_state);
        req_id = stim_state[31:16];
        tag = stim_state[15:8];
        stim_state = lcg_step(stim_state);
        word_a = stim_state;
        stim_state = lcg_step(stim_state);
        word_b = stim_state;
        four_dw = (fmttype == MRD64) || (fmttype == MWR64);
        // Upper address bits are random since the endpoint decodes only bits 6 to 2
        addr_word = four_dw ? word_a : {word_a[31:7], low_addr};
        lsb_word = four_dw ? {word_b[31:7], low_addr} : word_b;
        if ((fmttype == MRD32) || (fmttype == MRD64))
        begin
            exp_hdr_q.push_back({CPLD, 14'h0, length, 16'h0, 4'h0, {length, 2'b00},
                                 req_id, tag, 1'b0, {low_addr[6:2], 2'b00}, 32'h0});
            exp_data_q.push_back(expected_csr(low_addr[4:3]));
        end
        else if (((fmttype == MWR32) || (fmttype == MWR64)) &&
                 (low_addr[4:3] == `CSR_IDX_SCRATCH))
        begin
            model_scratch = payload;
        end
        rx_valid = 1'b1;
        rx_hdr = {fmttype, 14'h0, length, req_id, tag, 8'hff, addr_word, lsb_word};
        rx_data = payload;
        accepted = 1'b0;
        while (!accepted)
        begin
            // Inputs and flop outputs are settled by the falling edge
            @(negedge clk);
            accepted = rx_ready;
            @(posedge clk);
            #1;
        end
    endtask

    // Random back-pressure keeps ready high about three cycles in four
    initial
    begin
        tx_ready = 1'b0;
        bp_state = ~SEED;
        forever
        begin
            @(posedge clk);
            #1;
            bp_state = lcg_step(bp_state);
            tx_ready = (bp_state[31:30] != 2'b00);
        end
    end

    // A beat seen at the falling edge transfers on the next rising edge
    always @(negedge clk)
    begin
        if (reset_n && tx_valid && tx_ready)
        begin
            if (exp_hdr_q.size() == 0)
            begin
                $display("A completion arrived with no read outstanding at %0t", $time);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Unexpected completion");
            end
            else
            begin
                compare_field("tx_hdr.fmttype", exp_hdr_q[0][127:120], tx_hdr[127:120]);
                compare_field("tx_hdr.length", exp_hdr_q[0][105:96], tx_hdr[105:96]);
                compare_field("tx_hdr.byte_count", exp_hdr_q[0][75:64], tx_hdr[75:64]);
                compare_field("tx_hdr.requester_id", exp_hdr_q[0][63:48], tx_hdr[63:48]);
                compare_field("tx_hdr.tag", exp_hdr_q[0][47:40], tx_hdr[47:40]);
                compare_field("tx_hdr.lower_addr", exp_hdr_q[0][38:32], tx_hdr[38:32]);
                compare_field("tx_hdr", exp_hdr_q[0], tx_hdr);
                compare_field("tx_data", exp_data_q[0], tx_data);
                void'(exp_hdr_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
    end

    // Failures of the bound assertions end the run as well
    always @(negedge clk)
    begin
        if (u_dut.u_asserts.error_count != 0)
        begin
            $display("A bound protocol assertion failed at %0t", $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Protocol assertion failure");
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired with %0d completions still missing", exp_hdr_q.size());
        $display("TEST RESULT: FAIL");
        $fatal(1, "Timeout");
    end

    initial
    begin
        logic [31:0] r;
        logic [7:0]  code;
        rx_valid = 1'b0;
        rx_hdr = '0;
        rx_data = '0;
        stim_state = SEED;
        model_scratch = '0;
        @(posedge reset_n);
        compare_field("tx_valid", 1'b0, tx_valid);
        compare_field("rx_ready", 1'b1, rx_ready);

        // Scratch before any write, then the read-only words in both formats
        issue_request(MRD32, 7'h18, 10'd1, 64'h0);
        issue_request(MRD32, 7'h00, 10'd2, 64'h0);
        issue_request(MRD64, 7'h44, 10'd1, 64'h0);
        issue_request(MRD32, 7'h08, 10'd2, 64'h0);
        issue_request(MRD64, 7'h50, 10'd2, 64'h0);
        issue_request(MWR64, 7'h18, 10'd2, 64'h5ca1_ab1e_0123_4567);
        issue_request(MRD32, 7'h58, 10'd2, 64'h0);
        // Writes to read-only words must not stick
        issue_request(MWR32, 7'h00, 10'd2, 64'hffff_ffff_ffff_ffff);
        issue_request(MWR32, 7'h08, 10'd2, 64'h0bad_0bad_0bad_0bad);
        issue_request(MWR64, 7'h10, 10'd2, 64'h1234_5678_9abc_def0);
        idle_cycles(2);
        issue_request(MRD64, 7'h00, 10'd2, 64'h0);
        issue_request(MRD32, 7'h08, 10'd1, 64'h0);
        issue_request(MRD32, 7'h10, 10'd2, 64'h0);
        // Types the endpoint drops without an answer
        issue_request(CFGRD0, 7'h00, 10'd1, 64'h0);
        issue_request(CPL, 7'h18, 10'd1, 64'h0);
        issue_request(MRD64, 7'h18, 10'd2, 64'h0);

        // Mostly back-to-back random mix under random back-pressure
        for (int i = 0; i < N_RANDOM; i++)
        begin
            stim_state = lcg_step(stim_state);
            r = stim_state;
            case (r[31:29])
                3'd4, 3'd5: code = r[28] ? MWR64 : MWR32;
                3'd6:       code = r[28] ? CFGRD0 : CPL;
                default:    code = r[28] ? MRD64 : MRD32;
            endcase
            stim_state = lcg_step(stim_state);
            issue_request(code, {r[27:23], 2'b00}, r[22] ? 10'd2 : 10'd1, {stim_state, r});
            if (r[21:19] == 3'd0)
            begin
                idle_cycles(r[18:17] + 1);
            end
        end
        idle_cycles(1);

        while (exp_hdr_q.size() != 0)
        begin
            @(posedge clk);
        end
        // Any extra beat here is caught by the completion monitor
        repeat (20) @(posedge clk);
        // Assertion action blocks of this edge have all run 1 ns later
        #1;
        if (u_dut.u_asserts.error_count == 0)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("A bound protocol assertion failed near the end of the run");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Protocol assertion failure");
        end
    end

endmodule

`default_nettype wire

/* sim/mmio_endpoint_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions on the outbound stream
// Bound into the endpoint top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "mmio_defines.svh"

module mmio_endpoint_asserts (
    input logic                   clk,
    input logic                   reset_n,
    input logic                   tx_valid,
    input logic                   tx_ready,
    input logic [`TLP_HDR_W-1:0]  tx_hdr,
    input logic [`TLP_DATA_W-1:0] tx_data
);
    import tlp_pkg::*;

    // Number of assertion failures so far, the testbench watches it
    int error_count = 0;

    // A stalled completion keeps its valid, header and payload until taken
    a_tx_stall_stable: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_hdr) && $stable(tx_data))
    else
    begin
        error_count = error_count + 1;
        $error("tx beat changed while stalled");
    end

    // Reset clears the outbound valid on the following edge
    a_tx_idle_in_reset: assert property (@(posedge clk) !reset_n |=> !tx_valid)
    else
    begin
        error_count = error_count + 1;
        $error("tx_valid high during reset");
    end

    // The endpoint only ever sends completions with data
    a_tx_is_cpld: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid |-> (tx_hdr[127:120] == FMTTYPE_CPLD))
    else
    begin
        error_count = error_count + 1;
        $error("tx beat without the CplD code");
    end

endmodule

bind mmio_endpoint_top mmio_endpoint_asserts u_asserts (
    .clk      (clk),
    .reset_n  (reset_n),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_hdr   (tx_hdr),
    .tx_data  (tx_data)
);

`default_nettype wire

/* sim/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock, 4 ns period
// Synchronous reset held for 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release lands 1 ns after an edge, like every other driven input
    initial
    begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* hdl/mmio_endpoint_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMIO endpoint top level
// Inbound skid, responder, CSR block,
// outbound skid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "mmio_defines.svh"

module mmio_endpoint_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   rx_valid,
    output logic                   rx_ready,
    input  logic [`TLP_HDR_W-1:0]  rx_hdr,
    input  logic [`TLP_DATA_W-1:0] rx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output logic [`TLP_HDR_W-1:0]  tx_hdr,
    output logic [`TLP_DATA_W-1:0] tx_data
);

    // Inbound stream before and after its skid buffer
    tlp_stream_if rx_raw ();
    tlp_stream_if rx_reg ();
    // Outbound stream before and after its skid buffer
    tlp_stream_if tx_pre ();
    tlp_stream_if tx_raw ();

    logic [1:0]             csr_index;
    logic                   csr_wr_en;
    logic [`TLP_DATA_W-1:0] csr_wdata;
    logic [`TLP_DATA_W-1:0] csr_rdata;

    // Plain ports onto the interfaces
    assign rx_raw.valid = rx_valid;
    assign rx_raw.hdr   = rx_hdr;
    assign rx_raw.data  = rx_data;
    assign rx_ready     = rx_raw.ready;

    assign tx_valid     = tx_raw.valid;
    assign tx_hdr       = tx_raw.hdr;
    assign tx_data      = tx_raw.data;
    assign tx_raw.ready = tx_ready;

    tlp_skid_buffer u_rx_skid (
        .clk     (clk),
        .reset_n (reset_n),
        .in      (rx_raw),
        .out     (rx_reg)
    );

    mmio_responder u_responder (
        .clk       (clk),
        .reset_n   (reset_n),
        .rx        (rx_reg),
        .tx        (tx_pre),
        .csr_index (csr_index),
        .csr_wr_en (csr_wr_en),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata)
    );

    afu_csr u_csr (
        .clk       (clk),
        .reset_n   (reset_n),
        .csr_index (csr_index),
        .csr_wr_en (csr_wr_en),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata)
    );

    tlp_skid_buffer u_tx_skid (
        .clk     (clk),
        .reset_n (reset_n),
        .in      (tx_pre),
        .out     (tx_raw)
    );

endmodule

`default_nettype wire

/* hdl/mmio_responder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMIO request responder
// One-entry request hold, completion builder
// CSR write and read steering
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "mmio_defines.svh"

module mmio_responder (
    input  logic                   clk,
    input  logic                   reset_n,
    tlp_stream_if.sink             rx,
    tlp_stream_if.source           tx,
    output logic [1:0]             csr_index,
    output logic                   csr_wr_en,
    output logic [`TLP_DATA_W-1:0] csr_wdata,
    input  logic [`TLP_DATA_W-1:0] csr_rdata
);
    import tlp_pkg::*;

    // Held request, its payload and its sorted kind
    logic                   req_valid;
    logic                   req_rd;
    logic                   req_wr;
    tlp_mem_req_hdr_t       req_hdr;
    logic [`TLP_DATA_W-1:0] req_data;
    logic [4:0]             req_dw;
    logic                   rx_fire;
    tlp_hdr_t               cpl_word;

    // Only one request at a time, so the sink is open exactly when the hold is empty
    assign rx.ready = !req_valid;
    assign rx_fire  = rx.valid && rx.ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_valid <= 1'b0;
            req_rd    <= 1'b0;
            req_wr    <= 1'b0;
        end
        else if (rx_fire)
        begin
            req_valid <= 1'b1;
            req_rd    <= is_mem_rd(rx.hdr.req.fmttype);
            req_wr    <= is_mem_wr(rx.hdr.req.fmttype);
        end
        else if (req_valid && (!req_rd || tx.ready))
        begin
            // Reads wait for the completion to be taken, everything else
            // leaves after a single cycle
            req_valid <= 1'b0;
        end
    end

    // Inbound header word is decoded as a request
    always_ff @(posedge clk)
    begin
        if (rx_fire)
        begin
            req_hdr  <= rx.hdr.req;
            req_data <= rx.data;
        end
    end

    assign req_dw = req_dw_addr(req_hdr);

    // Address bits 4 to 3 select one 64-bit register
    assign csr_index = req_dw[2:1];
    assign csr_wr_en = req_valid && req_wr;
    assign csr_wdata = req_data;

    // Completion header, the same shape for every register
    always_comb
    begin
        cpl_word                  = '0;
        cpl_word.cpl.fmttype      = FMTTYPE_CPLD;
        cpl_word.cpl.length       = req_hdr.length;
        cpl_word.cpl.requester_id = req_hdr.requester_id;
        cpl_word.cpl.tag          = req_hdr.tag;
        // Byte count of the whole read, length in DW times 4
        cpl_word.cpl.byte_count   = {req_hdr.length, 2'b00};
        cpl_word.cpl.lower_addr   = {req_dw, 2'b00};
    end

    assign tx.valid = req_valid && req_rd;
    assign tx.hdr   = cpl_word;
    // The CSR block answers combinationally from the held index
    assign tx.data  = csr_rdata;

endmodule

`default_nettype wire

/* hdl/afu_csr.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AFU register block
// Feature header, AFU identifier, scratch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "mmio_defines.svh"

module afu_csr (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [1:0]             csr_index,
    input  logic                   csr_wr_en,
    input  logic [`TLP_DATA_W-1:0] csr_wdata,
    output logic [`TLP_DATA_W-1:0] csr_rdata
);

    // Feature type 1 (AFU) in bits 63 to 60, end of list in bit 40
    localparam logic [`TLP_DATA_W-1:0] DFH_WORD = {4'h1, 19'h0, 1'b1, 40'h0};

    logic [`TLP_DATA_W-1:0] scratch;

    // Only the scratch word is writable, writes elsewhere are dropped here
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            scratch <= '0;
        end
        else if (csr_wr_en && (csr_index == `CSR_IDX_SCRATCH))
        begin
            scratch <= csr_wdata;
        end
    end

    // Read mux, no wait states
    always_comb
    begin
        case (csr_index)
            `CSR_IDX_DFH:     csr_rdata = DFH_WORD;
            `CSR_IDX_ID_L:    csr_rdata = `AFU_ID_L;
            `CSR_IDX_ID_H:    csr_rdata = `AFU_ID_H;
            `CSR_IDX_SCRATCH: csr_rdata = scratch;
            default:          csr_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/tlp_skid_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry skid buffer for a TLP stream
// Registers valid, payload and ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "mmio_defines.svh"

module tlp_skid_buffer (
    input  logic         clk,
    input  logic         reset_n,
    tlp_stream_if.sink   in,
    tlp_stream_if.source out
);
    import tlp_pkg::*;

    // Main entry drives the output, skid entry catches a beat during a stall
    logic                   main_valid;
    tlp_hdr_t               main_hdr;
    logic [`TLP_DATA_W-1:0] main_data;
    logic                   skid_valid;
    tlp_hdr_t               skid_hdr;
    logic [`TLP_DATA_W-1:0] skid_data;

    logic in_fire;
    logic main_load;

    // Ready comes straight from a flop, so it never sees the downstream ready
    assign in.ready = !skid_valid;
    assign in_fire  = in.valid && in.ready;

    // Main entry is free when empty or when its beat leaves on this edge
    assign main_load = !main_valid || out.ready;

    assign out.valid = main_valid;
    assign out.hdr   = main_hdr;
    assign out.data  = main_data;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (main_load)
        begin
            // A waiting skid beat always goes first, in.ready was low meanwhile
            main_valid <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end
        else if (in_fire)
        begin
            // Output stalled with main full, the in-flight beat lands in skid
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_load)
        begin
            main_hdr  <= skid_valid ? skid_hdr : in.hdr;
            main_data <= skid_valid ? skid_data : in.data;
        end
        if (in_fire && !main_load)
        begin
            skid_hdr  <= in.hdr;
            skid_data <= in.data;
        end
    end

endmodule

`default_nettype wire

/* hdl/tlp_stream_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-beat TLP stream interface
// Source and sink modports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "mmio_defines.svh"

interface tlp_stream_if;
    import tlp_pkg::*;

    // A beat moves on a clock edge with valid and ready both high
    logic                   valid;
    logic                   ready;
    tlp_hdr_t               hdr;
    logic [`TLP_DATA_W-1:0] data;

    // The source holds valid, hdr and data steady until the beat is taken
    modport source (
        output valid,
        output hdr,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  hdr,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

/* hdl/tlp_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLP format/type codes and header structs
// Request/completion header union
// Header decode helper functions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package tlp_pkg;

    // Fmt in bits 7 to 5, type in bits 4 to 0; fmt bit 0 marks a 4 DW header
    typedef enum logic [7:0] {
        FMTTYPE_MRD32 = 8'h00,
        FMTTYPE_MRD64 = 8'h20,
        FMTTYPE_MWR32 = 8'h40,
        FMTTYPE_MWR64 = 8'h60,
        FMTTYPE_CPLD  = 8'h4a
    } tlp_fmttype_t;

    // Memory request header, first DW in the top bits
    typedef struct packed {
        tlp_fmttype_t fmttype;
        logic [13:0]  rsvd0;
        logic [9:0]   length;
        logic [15:0]  requester_id;
        logic [7:0]   tag;
        logic [7:0]   byte_en;
        // Full address of a 3 DW request, upper address of a 4 DW request
        logic [31:0]  addr;
        // Low address word of a 4 DW request
        logic [31:0]  lsb_addr;
    } tlp_mem_req_hdr_t;

    // Completion header, the fourth DW slot is unused
    typedef struct packed {
        tlp_fmttype_t fmttype;
        logic [13:0]  rsvd0;
        logic [9:0]   length;
        logic [15:0]  completer_id;
        logic [3:0]   rsvd1;
        logic [11:0]  byte_count;
        logic [15:0]  requester_id;
        logic [7:0]   tag;
        logic         rsvd2;
        logic [6:0]   lower_addr;
        logic [31:0]  rsvd3;
    } tlp_cpl_hdr_t;

    // The inbound path reads this word as a request, the outbound path as a completion
    typedef union packed {
        tlp_mem_req_hdr_t req;
        tlp_cpl_hdr_t     cpl;
    } tlp_hdr_t;

    function automatic logic is_addr64(tlp_fmttype_t fmttype);
        return fmttype[5];
    endfunction

    function automatic logic is_mem_rd(tlp_fmttype_t fmttype);
        return (fmttype == FMTTYPE_MRD32) || (fmttype == FMTTYPE_MRD64);
    endfunction

    function automatic logic is_mem_wr(tlp_fmttype_t fmttype);
        return (fmttype == FMTTYPE_MWR32) || (fmttype == FMTTYPE_MWR64);
    endfunction

    // DW address bits 6 to 2, from whichever word holds the low address
    function automatic logic [4:0] req_dw_addr(tlp_mem_req_hdr_t hdr);
        return is_addr64(hdr.fmttype) ? hdr.lsb_addr[6:2] : hdr.addr[6:2];
    endfunction

endpackage

`default_nettype wire

/* hdl/mmio_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream and payload widths of the MMIO endpoint
// AFU identifier words and the CSR index map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// One beat carries a full 4 DW header slot and a 2 DW payload
`define TLP_HDR_W 128
`define TLP_DATA_W 64

// AFU identifier, read back as two 64-bit words
`define AFU_ID_L 64'h9e61_0c5d_27b8_f143
`define AFU_ID_H 64'h8c2d_4e1a_b7f3_4a90

// CSR index is taken from address bits 4 to 3 (one index per 8-byte word)
`define CSR_IDX_DFH 2'd0
`define CSR_IDX_ID_L 2'd1
`define CSR_IDX_ID_H 2'd2
`define CSR_IDX_SCRATCH 2'd3

`endif
